/* sim.f */
logic/periph_pkg.sv
logic/periph_addr_decode.sv
logic/periph_read_buffer.sv
logic/gpio_regs.sv
logic/pin_func_mux.sv
logic/periph_fabric_top.sv
sim/tb_clk_gen.sv
sim/tb_periph_fabric.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the fail message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_fabric \
    -f sim.f -o tb_periph_fabric \
    && ./obj_dir/tb_periph_fabric > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

/* sim/tb_periph_fabric.sv */
// Peripheral fabric testbench
// Models the external user and simple slots, drives core requests and
// checks read data, write strobes, slot selects and output pins
`timescale 1ns/1ps

module tb_periph_fabric
    import periph_pkg::*;
();

    localparam int CLK_PERIOD_NS = 4;
    // Upper bound of the test sequence in clocks, with a wide margin
    localparam int TEST_CYCLES   = 250;
    localparam int WATCHDOG_NS   = 4 * TEST_CYCLES * CLK_PERIOD_NS;

    logic                                       clk;
    logic                                       rst_n;
    byte_t                                      ui_in;
    byte_t                                      uo_out;
    periph_req_t                                req;
    logic                                       read_complete;
    data_t                                      rdata;
    logic                                       ready;
    periph_req_t                                user_req;
    logic        [USER_SLOTS-1:0]               user_sel;
    logic        [SIMPLE_SLOTS-1:0]             simple_wr;
    user_rsp_t   [USER_SLOTS-1:EXT_USER_FIRST]  user_rsp;
    simple_rsp_t [SIMPLE_SLOTS-1:0]             simple_rsp;

    // Expectations set by the stimulus and checked by the assertions
    logic                    chk_idle;
    logic                    chk_read;
    logic                    chk_pins;
    logic                    chk_strobe;
    data_t                   exp_rdata;
    byte_t                   exp_pins;
    logic [USER_SLOTS-1:0]   exp_user_sel;
    logic [SIMPLE_SLOTS-1:0] exp_simple_wr;
    periph_req_t             exp_user_req;
    data_t                   data_bump;

    func_sel_t   model_func [NUM_PINS];
    byte_t       model_gpio_out;
    logic [15:0] lfsr_state;
    int          errors;
    int          tests_run;
    int          tests_passed;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(4)) u_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    periph_fabric_top u_periph_fabric_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .o_uo_out        (uo_out),
        .i_req           (req),
        .i_read_complete (read_complete),
        .o_rdata         (rdata),
        .o_ready         (ready),
        .o_user_req      (user_req),
        .o_user_sel      (user_sel),
        .o_simple_wr     (simple_wr),
        .i_user_rsp      (user_rsp),
        .i_simple_rsp    (simple_rsp)
    );

    // Rule value of user slot k at a slot offset
    function automatic data_t user_word(input int k, input logic [5:0] ofs);
        return data_t'(k) * 32'h0101_0101 + data_t'(ofs);
    endfunction

    // Slot models, data_bump moves user data during a held read
    always_comb begin
        for (int k = EXT_USER_FIRST; k < USER_SLOTS; k++) begin
            user_rsp[k].rdata = user_word(k, req.addr[5:0]) + data_bump;
            user_rsp[k].ready = 1'b1;
            user_rsp[k].pins  = byte_t'(k);
        end
        for (int k = 0; k < SIMPLE_SLOTS; k++) begin
            simple_rsp[k].rdata = 8'hA0 + byte_t'(k);
            simple_rsp[k].pins  = ~byte_t'(k);
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic addr_t user_addr(input int k, input logic [5:0] ofs);
        logic [4:0] slot;
        slot = 5'(k);
        if (k >= 16) begin
            return {2'b11, slot[2:0], ofs};
        end
        return {1'b0, slot[3:0], ofs};
    endfunction

    function automatic addr_t simple_addr(input int k);
        logic [3:0] slot;
        slot = 4'(k);
        return {3'b100, slot, 4'b0000};
    endfunction

    function automatic logic [USER_SLOTS-1:0] user_onehot(input int k);
        logic [USER_SLOTS-1:0] v;
        v = '0;
        v[k] = 1'b1;
        return v;
    endfunction

    function automatic logic [SIMPLE_SLOTS-1:0] simple_onehot(input int k);
        logic [SIMPLE_SLOTS-1:0] v;
        v = '0;
        v[k] = 1'b1;
        return v;
    endfunction

    // Output pins from the model function selects and GPIO byte
    function automatic byte_t expected_pins();
        byte_t     pins;
        byte_t     src;
        func_sel_t sel;
        int        slot;
        for (int p = 0; p < NUM_PINS; p++) begin
            sel = model_func[p];
            slot = int'({sel[5], sel[3:0]});
            if (sel[4]) begin
                src = ~byte_t'(sel[3:0]);
            end else if (slot == SLOT_RESERVED) begin
                src = '0;
            end else if (slot == SLOT_GPIO) begin
                src = model_gpio_out;
            end else begin
                src = byte_t'(slot);
            end
            pins[p] = src[p];
        end
        return pins;
    endfunction

    task automatic do_write(input addr_t addr, input data_t data,
                            input logic [USER_SLOTS-1:0] sel,
                            input logic [SIMPLE_SLOTS-1:0] swr);
        @(negedge clk);
        req.addr      = addr;
        req.wdata     = data;
        req.write_n   = 2'b00;
        req.read_n    = SIZE_IDLE;
        exp_user_sel  = sel;
        exp_simple_wr = swr;
        // User slots see the slot offset, simple slot writes keep both codes idle
        exp_user_req.addr    = addr_t'(addr[5:0]);
        exp_user_req.wdata   = data;
        exp_user_req.write_n = (swr == '0) ? 2'b00 : SIZE_IDLE;
        exp_user_req.read_n  = SIZE_IDLE;
        chk_strobe    = 1'b1;
        @(negedge clk);
        req.write_n = SIZE_IDLE;
        chk_strobe  = 1'b0;
    endtask

    // Read with the data held for hold_cycles before read complete
    task automatic do_read(input addr_t addr, input data_t exp, input int hold_cycles,
                           input logic [USER_SLOTS-1:0] sel);
        @(negedge clk);
        req.addr      = addr;
        req.read_n    = 2'b00;
        req.write_n   = SIZE_IDLE;
        exp_user_sel  = sel;
        exp_simple_wr = '0;
        exp_user_req.addr    = addr_t'(addr[5:0]);
        exp_user_req.wdata   = req.wdata;
        exp_user_req.write_n = SIZE_IDLE;
        exp_user_req.read_n  = (sel == '0) ? SIZE_IDLE : 2'b00;
        chk_strobe    = 1'b1;
        @(negedge clk);
        exp_rdata = exp;
        chk_read  = 1'b1;
        // The held result hides the read from the slot
        exp_user_req.read_n = SIZE_IDLE;
        repeat (hold_cycles) begin
            data_bump = data_bump + 32'h0001_0003;
            @(negedge clk);
        end
        read_complete = 1'b1;
        req.read_n    = SIZE_IDLE;
        @(negedge clk);
        read_complete = 1'b0;
        chk_read      = 1'b0;
        chk_strobe    = 1'b0;
        data_bump     = '0;
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            tests_passed++;
            $display("[%0d] %s ... pass", tests_run, name);
        end else begin
            $display("[%0d] %s ... fail (%0d errors)", tests_run, name,
                     errors - errs_at_start);
        end
    endtask

    idle_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        chk_idle |-> !ready)
        else begin
            errors++;
            $display("FAILED at time %0t: o_ready high with no request", $time);
        end

    write_acked: assert property (@(posedge clk) disable iff (!rst_n)
        (req.write_n != SIZE_IDLE) |-> ready)
        else begin
            errors++;
            $display("FAILED at time %0t: write not acknowledged", $time);
        end

    read_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
        chk_read |-> (ready && rdata == exp_rdata))
        else begin
            errors++;
            $display("FAILED at time %0t: read data %h ready %b, expected %h", $time,
                     $sampled(rdata), $sampled(ready), exp_rdata);
        end

    pins_ok: assert property (@(posedge clk) disable iff (!rst_n)
        chk_pins |-> (uo_out == exp_pins))
        else begin
            errors++;
            $display("FAILED at time %0t: pins %h, expected %h", $time,
                     $sampled(uo_out), exp_pins);
        end

    strobes_ok: assert property (@(posedge clk) disable iff (!rst_n)
        chk_strobe |-> (user_sel == exp_user_sel && simple_wr == exp_simple_wr))
        else begin
            errors++;
            $display("FAILED at time %0t: user sel %h simple wr %h, expected %h %h", $time,
                     $sampled(user_sel), $sampled(simple_wr), exp_user_sel, exp_simple_wr);
        end

    user_req_ok: assert property (@(posedge clk) disable iff (!rst_n)
        chk_strobe |-> (user_req == exp_user_req))
        else begin
            errors++;
            $display("FAILED at time %0t: user request %h, expected %h", $time,
                     $sampled(user_req), exp_user_req);
        end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int          start;
        int          k;
        logic [31:0] r;
        logic [31:0] hi;
        logic [5:0]  ofs;
        func_sel_t   sel;

        req           = '{addr: '0, wdata: '0, write_n: SIZE_IDLE, read_n: SIZE_IDLE};
        read_complete = 1'b0;
        ui_in         = '0;
        chk_idle      = 1'b0;
        chk_read      = 1'b0;
        chk_pins      = 1'b0;
        chk_strobe    = 1'b0;
        exp_rdata     = '0;
        exp_user_sel  = '0;
        exp_simple_wr = '0;
        exp_user_req  = '{addr: '0, wdata: '0, write_n: SIZE_IDLE, read_n: SIZE_IDLE};
        data_bump     = '0;
        lfsr_state    = 16'd19611;
        errors        = 0;
        tests_run     = 0;
        tests_passed  = 0;
        model_gpio_out = '0;
        for (int p = 0; p < NUM_PINS; p++) begin
            model_func[p] = (p < 2) ? FUNC_DEFAULT_UART : FUNC_DEFAULT_GPIO;
        end
        exp_pins = expected_pins();
        wait (rst_n === 1'b1);
        @(negedge clk);

        start    = errors;
        chk_pins = 1'b1;
        chk_idle = 1'b1;
        repeat (4) @(negedge clk);
        chk_idle = 1'b0;
        end_test("reset defaults", start);

        start = errors;
        rand_bits(8, r);
        do_write(user_addr(SLOT_GPIO, GPIO_OUT_OFS), r, user_onehot(SLOT_GPIO), '0);
        model_gpio_out = byte_t'(r);
        exp_pins = expected_pins();
        do_read(user_addr(SLOT_GPIO, GPIO_OUT_OFS), {24'b0, r[7:0]}, 0, user_onehot(SLOT_GPIO));
        rand_bits(8, r);
        ui_in = byte_t'(r);
        do_read(user_addr(SLOT_GPIO, GPIO_IN_OFS), {24'b0, r[7:0]}, 0, user_onehot(SLOT_GPIO));
        end_test("GPIO output and input", start);

        start = errors;
        for (int i = 0; i < 8; i++) begin
            rand_bits(3, r);
            k = int'(r[2:0]);
            rand_bits(5, r);
            // Either a simple slot or any user slot 0 to 23
            if (r[4]) begin
                sel = {2'b01, r[3:0]};
            end else begin
                rand_bits(5, r);
                r = r % 24;
                sel = {r[4], 1'b0, r[3:0]};
            end
            rand_bits(26, hi);
            ofs = 6'(32 + 4 * k);
            do_write(user_addr(SLOT_GPIO, ofs), {hi[25:0], sel}, user_onehot(SLOT_GPIO), '0);
            model_func[k] = sel;
            exp_pins = expected_pins();
            do_read(user_addr(SLOT_GPIO, ofs), {26'b0, sel}, 0, user_onehot(SLOT_GPIO));
        end
        end_test("pin function select", start);

        start = errors;
        for (int i = 0; i < 6; i++) begin
            rand_bits(5, r);
            k = EXT_USER_FIRST + int'(r % 22);
            rand_bits(6, r);
            ofs = r[5:0];
            do_read(user_addr(k, ofs), user_word(k, ofs), 3, user_onehot(k));
        end
        end_test("user slot held read", start);

        start = errors;
        for (int i = 0; i < 5; i++) begin
            rand_bits(4, r);
            k = int'(r[3:0]);
            rand_bits(32, hi);
            do_write(simple_addr(k), hi, '0, simple_onehot(k));
            do_read(simple_addr(k), {24'b0, 8'hA0 + 8'(k)}, 0, '0);
        end
        for (k = 16; k < USER_SLOTS; k++) begin
            rand_bits(6, r);
            ofs = r[5:0];
            do_read(user_addr(k, ofs), user_word(k, ofs), 0, user_onehot(k));
        end
        end_test("simple slots and upper user bank", start);

        repeat (2) @(negedge clk);
        $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* sim/tb_clk_gen.sv */
// Testbench clock and reset generator
// Free running clock and a synchronous active low reset held for a few cycles
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge so the first active edge sees a clean level
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* logic/periph_fabric_top.sv */
// Peripheral fabric top level
// Joins address decode, read buffer, GPIO block and output pin mux.
// External user and simple slots connect through the packed struct ports
`timescale 1ns/1ps

module periph_fabric_top
    import periph_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  byte_t                                       i_ui_in,
    output byte_t                                       o_uo_out,
    input  periph_req_t                                 i_req,
    input  logic                                        i_read_complete,
    output data_t                                       o_rdata,
    output logic                                        o_ready,
    output periph_req_t                                 o_user_req,
    output logic        [USER_SLOTS-1:0]                o_user_sel,
    output logic        [SIMPLE_SLOTS-1:0]              o_simple_wr,
    input  user_rsp_t   [USER_SLOTS-1:EXT_USER_FIRST]   i_user_rsp,
    input  simple_rsp_t [SIMPLE_SLOTS-1:0]              i_simple_rsp
);

    size_n_t   read_n_masked;
    data_t     rsp_data;
    logic      rsp_ready;
    user_rsp_t gpio_rsp;

    func_sel_t [NUM_PINS-1:0]     func_sel;
    byte_t     [USER_SLOTS-1:0]   user_pins;
    byte_t     [SIMPLE_SLOTS-1:0] simple_pins;

    periph_read_buffer u_periph_read_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_req.read_n),
        .i_write_n       (i_req.write_n),
        .i_rsp_data      (rsp_data),
        .i_rsp_ready     (rsp_ready),
        .i_read_complete (i_read_complete),
        .o_read_n_masked (read_n_masked),
        .o_rdata         (o_rdata),
        .o_ready         (o_ready)
    );

    periph_addr_decode u_periph_addr_decode (
        .i_req           (i_req),
        .i_read_n_masked (read_n_masked),
        .i_gpio_rsp      (gpio_rsp),
        .i_user_rsp      (i_user_rsp),
        .i_simple_rsp    (i_simple_rsp),
        .o_user_req      (o_user_req),
        .o_user_sel      (o_user_sel),
        .o_simple_wr     (o_simple_wr),
        .o_rdata         (rsp_data),
        .o_rsp_ready     (rsp_ready)
    );

    // GPIO sees the same slot relative request as the external slots
    gpio_regs u_gpio_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (o_user_req),
        .i_sel      (o_user_sel[SLOT_GPIO]),
        .i_ui_in    (i_ui_in),
        .o_rsp      (gpio_rsp),
        .o_func_sel (func_sel)
    );

    // Pin buses for the mux, slot 0 drives nothing
    always_comb begin
        user_pins[SLOT_RESERVED] = '0;
        user_pins[SLOT_GPIO]     = gpio_rsp.pins;
        for (int k = EXT_USER_FIRST; k < USER_SLOTS; k++) begin
            user_pins[k] = i_user_rsp[k].pins;
        end
        for (int k = 0; k < SIMPLE_SLOTS; k++) begin
            simple_pins[k] = i_simple_rsp[k].pins;
        end
    end

    pin_func_mux u_pin_func_mux (
        .i_func_sel    (func_sel),
        .i_user_pins   (user_pins),
        .i_simple_pins (simple_pins),
        .o_uo_out      (o_uo_out)
    );

endmodule

/* logic/pin_func_mux.sv */
// Output pin function mux
// Each output pin takes its own bit from the user or simple slot
// named by that pin's function select
`timescale 1ns/1ps

module pin_func_mux
    import periph_pkg::*;
(
    input  func_sel_t [NUM_PINS-1:0]     i_func_sel,
    input  byte_t     [USER_SLOTS-1:0]   i_user_pins,
    input  byte_t     [SIMPLE_SLOTS-1:0] i_simple_pins,
    output byte_t                        o_uo_out
);

    logic [NUM_PINS-1:0] sel_bad;

    always_comb begin
        for (int p = 0; p < NUM_PINS; p++) begin
            // User slot numbers above 23 do not exist
            sel_bad[p] = !i_func_sel[p][4] && i_func_sel[p][5] && i_func_sel[p][3];
            if (i_func_sel[p][4]) begin
                o_uo_out[p] = i_simple_pins[i_func_sel[p][3:0]][p];
            end else begin
                o_uo_out[p] = i_user_pins[{i_func_sel[p][5], i_func_sel[p][3:0]}][p];
            end
        end

        assert ((|sel_bad) !== 1'b1)
            else $error("pin function select names a missing user slot");
    end

endmodule

/* logic/gpio_regs.sv */
// GPIO block on user slot 1
// Output byte register, input pin readback and one output function
// select register per pin
`timescale 1ns/1ps

module gpio_regs
    import periph_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  periph_req_t                 i_req,
    input  logic                        i_sel,
    input  byte_t                       i_ui_in,
    output user_rsp_t                   o_rsp,
    output func_sel_t [NUM_PINS-1:0]    o_func_sel
);

    logic [SLOT_OFS_W-1:0]       ofs;
    logic [$clog2(NUM_PINS)-1:0] func_idx;
    logic                        wr_en;
    logic                        func_hit;
    byte_t                       gpio_out;

    assign ofs      = i_req.addr[SLOT_OFS_W-1:0];
    assign func_idx = ofs[4:2];
    assign wr_en    = i_sel && (i_req.write_n != SIZE_IDLE);
    // Word aligned offsets 32 to 60
    assign func_hit = (ofs & 6'h23) == GPIO_FUNC_OFS;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && ofs == GPIO_OUT_OFS) begin
            gpio_out <= i_req.wdata[BYTE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PINS; p++) begin
                // Pins 0 and 1 come up on the UART slot
                o_func_sel[p] <= (p < 2) ? FUNC_DEFAULT_UART : FUNC_DEFAULT_GPIO;
            end
        end else if (wr_en && func_hit) begin
            o_func_sel[func_idx] <= i_req.wdata[FUNC_W-1:0];
        end
    end

    always_comb begin
        o_rsp.rdata = '0;
        if (ofs == GPIO_OUT_OFS) begin
            o_rsp.rdata = data_t'(gpio_out);
        end else if (ofs == GPIO_IN_OFS) begin
            o_rsp.rdata = data_t'(i_ui_in);
        end else if (func_hit) begin
            o_rsp.rdata = data_t'(o_func_sel[func_idx]);
        end
        // Register access always completes in the same cycle
        o_rsp.ready = 1'b1;
        o_rsp.pins  = gpio_out;
    end

endmodule

/* logic/periph_read_buffer.sv */
// Peripheral read buffer
// Captures the slot read data and holds it until the core signals read
// complete, and masks further reads while the registered ready is up
`timescale 1ns/1ps

module periph_read_buffer
    import periph_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  size_n_t i_read_n,
    input  size_n_t i_write_n,
    input  data_t   i_rsp_data,
    input  logic    i_rsp_ready,
    input  logic    i_read_complete,
    output size_n_t o_read_n_masked,
    output data_t   o_rdata,
    output logic    o_ready
);

    logic  read_req;
    logic  capture;
    logic  hold;
    logic  ready_r;
    data_t rdata_r;

    assign read_req = (i_read_n != SIZE_IDLE);
    assign capture  = !hold && i_rsp_ready && read_req;

    // Stop the slot seeing a second read while the result waits
    assign o_read_n_masked = i_read_n | {SIZE_W{ready_r}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            ready_r <= read_req && i_rsp_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_r <= i_rsp_data;
        end
    end

    assign o_rdata = rdata_r;
    // Writes are acknowledged in the same cycle
    assign o_ready = ready_r || (i_write_n != SIZE_IDLE);

endmodule

/* logic/periph_addr_decode.sv */
// Peripheral address decode
// Picks one user or simple slot from the core address, gates the request
// so only that slot sees it, and muxes the selected slot's response
`timescale 1ns/1ps

module periph_addr_decode
    import periph_pkg::*;
(
    input  periph_req_t                                   i_req,
    input  size_n_t                                       i_read_n_masked,
    input  user_rsp_t                                     i_gpio_rsp,
    input  user_rsp_t   [USER_SLOTS-1:EXT_USER_FIRST]     i_user_rsp,
    input  simple_rsp_t [SIMPLE_SLOTS-1:0]                i_simple_rsp,
    output periph_req_t                                   o_user_req,
    output logic        [USER_SLOTS-1:0]                  o_user_sel,
    output logic        [SIMPLE_SLOTS-1:0]                o_simple_wr,
    output data_t                                         o_rdata,
    output logic                                          o_rsp_ready
);

    logic [USER_IDX_W-1:0]   user_idx;
    logic [SIMPLE_IDX_W-1:0] simple_idx;
    logic                    simple_hit;
    logic                    write_req;
    user_rsp_t [USER_SLOTS-1:0] user_rsp_all;

    assign write_req  = (i_req.write_n != SIZE_IDLE);
    assign simple_idx = i_req.addr[7:4];

    always_comb begin
        user_idx   = '0;
        simple_hit = 1'b0;
        case (i_req.addr[10:9])
            2'b10:   simple_hit = 1'b1;
            // Upper user bank, slots 16 to 23
            2'b11:   user_idx = {2'b10, i_req.addr[8:6]};
            default: user_idx = {1'b0, i_req.addr[9:6]};
        endcase
    end

    // Full user response set, slot 0 reads as zero and never goes ready
    always_comb begin
        user_rsp_all[USER_SLOTS-1:EXT_USER_FIRST] = i_user_rsp;
        user_rsp_all[SLOT_RESERVED]               = '0;
        user_rsp_all[SLOT_GPIO]                   = i_gpio_rsp;
    end

    always_comb begin
        o_user_sel  = '0;
        o_simple_wr = '0;
        if (simple_hit) begin
            o_simple_wr[simple_idx] = write_req;
        end else begin
            o_user_sel[user_idx] = 1'b1;
        end

        // Shared request, codes forced idle when a simple slot is addressed
        o_user_req.addr    = addr_t'(i_req.addr[SLOT_OFS_W-1:0]);
        o_user_req.wdata   = i_req.wdata;
        o_user_req.write_n = simple_hit ? SIZE_IDLE : i_req.write_n;
        o_user_req.read_n  = simple_hit ? SIZE_IDLE : i_read_n_masked;

        // Simple slots are byte wide and always ready
        if (simple_hit) begin
            o_rdata     = data_t'(i_simple_rsp[simple_idx].rdata);
            o_rsp_ready = 1'b1;
        end else begin
            o_rdata     = user_rsp_all[user_idx].rdata;
            o_rsp_ready = user_rsp_all[user_idx].ready;
        end
    end

endmodule

/* logic/periph_pkg.sv */
// Peripheral fabric package
// Bus widths, slot counts, address map constants and the request and
// response bundles shared by the decode, read buffer, GPIO and pin mux
package periph_pkg;

    localparam int ADDR_W       = 11;
    localparam int DATA_W       = 32;
    localparam int BYTE_W       = 8;
    localparam int SIZE_W       = 2;
    localparam int FUNC_W       = 6;
    localparam int SLOT_OFS_W   = 6;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BYTE_W-1:0] byte_t;
    // Active low size code, 3 is idle, 0/1/2 are 8/16/32 bits
    typedef logic [SIZE_W-1:0] size_n_t;
    typedef logic [FUNC_W-1:0] func_sel_t;

    // Slot counts
    localparam int USER_SLOTS     = 24;
    localparam int SIMPLE_SLOTS   = 16;
    localparam int EXT_USER_FIRST = 2;
    localparam int USER_IDX_W     = $clog2(USER_SLOTS);
    localparam int SIMPLE_IDX_W   = $clog2(SIMPLE_SLOTS);
    localparam int NUM_PINS       = 8;

    // Address map
    localparam int      SLOT_RESERVED = 0;
    localparam int      SLOT_GPIO     = 1;
    localparam size_n_t SIZE_IDLE     = 2'b11;

    // GPIO register offsets within the slot
    localparam logic [SLOT_OFS_W-1:0] GPIO_OUT_OFS  = 6'd0;
    localparam logic [SLOT_OFS_W-1:0] GPIO_IN_OFS   = 6'd4;
    localparam logic [SLOT_OFS_W-1:0] GPIO_FUNC_OFS = 6'd32;

    // Function select reset values
    localparam func_sel_t FUNC_DEFAULT_UART = 6'd2;
    localparam func_sel_t FUNC_DEFAULT_GPIO = 6'd1;

    typedef struct packed {
        addr_t   addr;
        data_t   wdata;
        size_n_t write_n;
        size_n_t read_n;
    } periph_req_t;

    typedef struct packed {
        data_t rdata;
        logic  ready;
        byte_t pins;
    } user_rsp_t;

    typedef struct packed {
        byte_t rdata;
        byte_t pins;
    } simple_rsp_t;

endpackage
